// ==== bench/cpu_tb.sv ====
`timescale 1ns/1ns

module cpu_tb;
    import cpu_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int LOOP_ADDS    = 10;       // x2 counts down from 10 to 1.
    localparam int LOOP_SUM     = LOOP_ADDS * (LOOP_ADDS + 1) / 2;
    localparam int STORE_ADDR   = 64;
    localparam int SPIN_PC      = 48;
    localparam int SPIN_REPEATS = 5;
    localparam int CYCLE_LIMIT  = 200;      // Reset plus about 52 retires fits with ample margin.

    logic        clk = 1'b0;
    logic        rst_n;
    retire_t     retire;
    retire_t     cur = '0;                  // Retire record held from one falling edge to the next.
    retire_t     prev = '0;
    logic        cur_rst_n = 1'b0;
    int unsigned add_count = 0;
    int unsigned store_count = 0;
    int unsigned beq8_tests = 0;
    int unsigned spin_count = 0;
    int unsigned cycles = 0;

    cpu_top dut_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .retire (retire)
    );

    always #20 clk = ~clk;

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "cpu_tb stopped at the first failure");
    endtask

    task automatic report_mismatch(input string test, input word_t expected, input word_t actual);
        abort_run($sformatf("ERROR %s: expected %0d, actual %0d", test, expected, actual));
    endtask

    // The loop exits on the eleventh test of the branch at 8, once x2 has reached zero.
    function automatic word_t next_pc(input word_t pc, input int unsigned tests_at_8);
        case (pc)
            32'd8:   return (tests_at_8 == LOOP_ADDS + 1) ? 32'd24 : 32'd12;
            32'd20:  return 32'd8;
            32'd48:  return 32'd48;
            default: return pc + 32'd4;
        endcase
    endfunction

    function automatic reg_addr_t expected_rd(input word_t pc);
        case (pc)
            32'd28:  return 5'd3;
            32'd32:  return 5'd4;
            32'd36:  return 5'd5;
            32'd40:  return 5'd6;
            default: return 5'd0;
        endcase
    endfunction

    // The load returns the stored sum and the three ALU results follow from it.
    function automatic word_t expected_rd_data(input word_t pc);
        case (pc)
            32'd28:  return word_t'(LOOP_SUM);
            32'd32:  return 32'd0;
            32'd36:  return 32'd1;
            default: return word_t'(LOOP_SUM | 1);
        endcase
    endfunction

    always @(negedge clk) begin
        prev      <= cur;
        cur       <= retire;
        cur_rst_n <= rst_n;
        if (retire.valid && retire.pc == 32'd12) begin
            add_count <= add_count + 1;
        end
        if (retire.valid && retire.pc == 32'd8) begin
            beq8_tests <= beq8_tests + 1;
        end
        if (retire.store) begin
            store_count <= store_count + 1;
        end
        if (retire.valid && retire.pc == SPIN_PC) begin
            spin_count <= spin_count + 1;
        end else begin
            spin_count <= 0;
        end
    end

    always @(negedge clk) begin
        cycles <= cycles + 1;
        if (spin_count == SPIN_REPEATS) begin
            if (add_count == LOOP_ADDS && store_count == 1) begin
                $display("=== PASS ===");
                $finish;
            end else if (add_count != LOOP_ADDS) begin
                report_mismatch("add count", word_t'(LOOP_ADDS), word_t'(add_count));
            end else begin
                report_mismatch("store count", 32'd1, word_t'(store_count));
            end
        end else if (cycles == CYCLE_LIMIT) begin
            abort_run($sformatf(
                "Timeout: the program did not settle at pc %0d within %0d cycles.",
                SPIN_PC, CYCLE_LIMIT));
        end
    end

    reset_quiet: assert property (@(posedge clk)
        !cur_rst_n |-> !(cur.valid || cur.store || cur.rd_we)
    ) else report_mismatch("reset", 32'd0, word_t'({cur.valid, cur.store, cur.rd_we}));
    first_pc: assert property (@(posedge clk) (cur.valid && !prev.valid) |-> cur.pc == 32'd0)
        else report_mismatch("first pc", 32'd0, cur.pc);
    pc_sequence: assert property (@(posedge clk)
        (cur.valid && prev.valid) |-> cur.pc == next_pc(prev.pc, beq8_tests)
    ) else report_mismatch("control flow", next_pc(prev.pc, beq8_tests), cur.pc);
    loop_adds: assert property (@(posedge clk)
        (cur.valid && cur.pc == 32'd24) |-> add_count == LOOP_ADDS
    ) else report_mismatch("loop adds", word_t'(LOOP_ADDS), word_t'(add_count));
    store_addr: assert property (@(posedge clk) cur.store |-> cur.mem_addr == STORE_ADDR)
        else report_mismatch("store address", STORE_ADDR, cur.mem_addr);
    store_data: assert property (@(posedge clk) cur.store |-> cur.mem_data == LOOP_SUM)
        else report_mismatch("store data", LOOP_SUM, cur.mem_data);
    wb_dest: assert property (@(posedge clk)
        (cur.valid && expected_rd(cur.pc) != '0) |-> cur.rd_we && cur.rd == expected_rd(cur.pc)
    ) else report_mismatch("writeback rd", word_t'(expected_rd(cur.pc)), word_t'(cur.rd));
    wb_value: assert property (@(posedge clk)
        (cur.valid && expected_rd(cur.pc) != '0) |-> cur.rd_data == expected_rd_data(cur.pc)
    ) else report_mismatch("writeback data", expected_rd_data(cur.pc), cur.rd_data);
    x0_addi: assert property (@(posedge clk) (cur.valid && cur.pc == 32'd44) |-> !cur.rd_we)
        else report_mismatch("x0 addi write enable", 32'd0, word_t'(cur.rd_we));
    x0_guard: assert property (@(posedge clk) (cur.valid && cur.rd_we) |-> cur.rd != '0)
        else abort_run($sformatf("A write to x0 was retired at pc %0d.", cur.pc));

endmodule

// ==== list.f ====
rtl/cpu_pkg.sv
rtl/fetch_unit.sv
rtl/decode_control.sv
rtl/register_file.sv
rtl/alu.sv
rtl/memory_access.sv
rtl/cpu_top.sv
bench/cpu_tb.sv

// ==== rtl/alu.sv ====
`timescale 1ns/1ns

module alu (
    input  cpu_pkg::word_t  a,
    input  cpu_pkg::word_t  b,
    input  cpu_pkg::word_t  imm,
    input  logic            alu_src,
    input  cpu_pkg::alu_op_t alu_op,
    output cpu_pkg::word_t  result,
    output logic            zero
);
    import cpu_pkg::*;

    word_t operand;

    assign operand = alu_src ? imm : b;

    always_comb begin
        case (alu_op)
            ALU_ADD: result = a + operand;
            ALU_SUB: result = a - operand;
            ALU_AND: result = a & operand;
            ALU_OR:  result = a | operand;
            ALU_SLT: result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(operand)};
            default: result = '0;
        endcase
        zero = (result == '0);
        // beq relies on zero meaning the two operands are equal.
        if (alu_op == ALU_SUB) begin
            assert (zero == (a == operand))
                else $error("alu: zero flag disagrees with operand equality");
        end
    end

endmodule

// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [2:0]      alu_op_t;

    localparam opcode_t OP_RTYPE  = 7'b0110011;
    localparam opcode_t OP_ITYPE  = 7'b0010011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_SLT = 3'd4;

    localparam int IMEM_WORDS  = 64;
    localparam int DMEM_WORDS  = 64;
    localparam int IMEM_ADDR_W = $clog2(IMEM_WORDS);
    localparam int DMEM_ADDR_W = $clog2(DMEM_WORDS);

    typedef struct packed {
        word_t pc;
        word_t inst;
    } fetch_t;

    typedef struct packed {
        logic    alu_src;    // Second operand comes from the immediate.
        logic    mem_to_reg;
        logic    reg_write;
        logic    mem_write;
        logic    branch;
        alu_op_t alu_op;
    } ctrl_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        logic      rd_we;
        word_t     rd_data;
        logic      store;
        word_t     mem_addr;
        word_t     mem_data;
    } retire_t;

endpackage

// ==== rtl/cpu_top.sv ====
`timescale 1ns/1ns

module cpu_top (
    input  logic              clk,
    input  logic              rst_n,
    output cpu_pkg::retire_t  retire
);
    import cpu_pkg::*;

    fetch_t    fetch;
    ctrl_t     ctrl;
    word_t     imm;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     alu_result;
    word_t     wb_data;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    logic      zero;
    logic      branch_taken;

    fetch_unit u_fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .branch_taken (branch_taken),
        .imm          (imm),
        .fetch        (fetch)
    );

    decode_control u_decode (
        .inst         (fetch.inst),
        .zero         (zero),
        .ctrl         (ctrl),
        .imm          (imm),
        .rs1          (rs1),
        .rs2          (rs2),
        .rd           (rd),
        .branch_taken (branch_taken)
    );

    register_file u_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .rs1          (rs1),
        .rs2          (rs2),
        .rd           (rd),
        .reg_write    (ctrl.reg_write),
        .wb_data      (wb_data),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data)
    );

    alu u_alu (
        .a            (rs1_data),
        .b            (rs2_data),
        .imm          (imm),
        .alu_src      (ctrl.alu_src),
        .alu_op       (ctrl.alu_op),
        .result       (alu_result),
        .zero         (zero)
    );

    memory_access u_mem (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch        (fetch),
        .ctrl         (ctrl),
        .rd           (rd),
        .alu_result   (alu_result),
        .store_data   (rs2_data),
        .wb_data      (wb_data),
        .retire       (retire)
    );

endmodule

// ==== rtl/decode_control.sv ====
`timescale 1ns/1ns

module decode_control (
    input  cpu_pkg::word_t     inst,
    input  logic               zero,
    output cpu_pkg::ctrl_t     ctrl,
    output cpu_pkg::word_t     imm,
    output cpu_pkg::reg_addr_t rs1,
    output cpu_pkg::reg_addr_t rs2,
    output cpu_pkg::reg_addr_t rd,
    output logic               branch_taken
);
    import cpu_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;

    // R and I types share the funct3 encoding, only sub needs funct7.
    function automatic alu_op_t funct_to_alu(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  return sub ? ALU_SUB : ALU_ADD;
            3'b010:  return ALU_SLT;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign rd     = inst[11:7];

    always_comb begin
        ctrl        = '0;                   // Unknown opcodes retire as no-ops.
        ctrl.alu_op = ALU_ADD;
        case (opcode)
            OP_RTYPE: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = funct_to_alu(funct3, inst[30]);
            end
            OP_ITYPE: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = funct_to_alu(funct3, 1'b0);
            end
            OP_LOAD: begin
                ctrl.alu_src    = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.reg_write  = 1'b1;
            end
            OP_STORE: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            OP_BRANCH: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = ALU_SUB;      // beq compares by subtraction.
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    always_comb begin
        case (opcode)
            OP_ITYPE, OP_LOAD: imm = {{20{inst[31]}}, inst[31:20]};
            OP_STORE:          imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            OP_BRANCH:         imm = {{19{inst[31]}}, inst[31], inst[7],
                                      inst[30:25], inst[11:8], 1'b0};
            default:           imm = '0;
        endcase
    end

    assign branch_taken = ctrl.branch & zero;

endmodule

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ns

module fetch_unit (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            branch_taken,
    input  cpu_pkg::word_t  imm,
    output cpu_pkg::fetch_t fetch
);
    import cpu_pkg::*;

    word_t pc;
    word_t pc_next;
    word_t imem [IMEM_WORDS];

    initial begin
        $readmemh("rtl/program.hex", imem); // Path is relative to the project root.
    end

    always_comb begin
        if (branch_taken) begin
            pc_next = pc + imm;             // Branch target from the B immediate.
        end else begin
            pc_next = pc + word_t'(4);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    always_comb begin
        fetch.pc   = pc;
        fetch.inst = imem[pc[IMEM_ADDR_W+1:2]];
    end

    // The program must never run off the end of the ROM or land between words.
    pc_in_imem: assert property (
        @(posedge clk) disable iff (!rst_n)
        (pc[1:0] == 2'b00) && (pc < word_t'(IMEM_WORDS * 4))
    ) else $error("fetch_unit: pc %h outside instruction memory", pc);

endmodule

// ==== rtl/memory_access.sv ====
`timescale 1ns/1ns

module memory_access (
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_pkg::fetch_t    fetch,
    input  cpu_pkg::ctrl_t     ctrl,
    input  cpu_pkg::reg_addr_t rd,
    input  cpu_pkg::word_t     alu_result,
    input  cpu_pkg::word_t     store_data,
    output cpu_pkg::word_t     wb_data,
    output cpu_pkg::retire_t   retire
);
    import cpu_pkg::*;

    word_t                  dmem [DMEM_WORDS];
    logic [DMEM_ADDR_W-1:0] word_idx;

    assign word_idx = alu_result[DMEM_ADDR_W+1:2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (ctrl.mem_write) begin
            dmem[word_idx] <= store_data;
        end
    end

    assign wb_data = ctrl.mem_to_reg ? dmem[word_idx] : alu_result;

    always_comb begin
        retire.valid    = rst_n;            // One instruction retires per cycle out of reset.
        retire.pc       = fetch.pc;
        retire.rd       = rd;
        retire.rd_we    = rst_n & ctrl.reg_write & (rd != '0);
        retire.rd_data  = wb_data;
        retire.store    = rst_n & ctrl.mem_write;
        retire.mem_addr = alu_result;
        retire.mem_data = store_data;
    end

    dmem_addr_ok: assert property (
        @(posedge clk) disable iff (!rst_n)
        (ctrl.mem_write || ctrl.mem_to_reg) |->
            (alu_result[1:0] == 2'b00) && (alu_result < word_t'(DMEM_WORDS * 4))
    ) else $error("memory_access: bad data address %h at pc %h", alu_result, fetch.pc);

endmodule

// ==== rtl/program.hex ====
// One RV32I instruction word per line, loaded from byte address 0.
00000093 // 0:  addi x1, x0, 0
00A00113 // 4:  addi x2, x0, 10
00010863 // 8:  beq  x2, x0, +16
002080B3 // 12: add  x1, x1, x2
FFF10113 // 16: addi x2, x2, -1
FE000AE3 // 20: beq  x0, x0, -12
04102023 // 24: sw   x1, 64(x0)
04002183 // 28: lw   x3, 64(x0)
40118233 // 32: sub  x4, x3, x1
003222B3 // 36: slt  x5, x4, x3
0051E333 // 40: or   x6, x3, x5
00500013 // 44: addi x0, x0, 5
00000063 // 48: beq  x0, x0, 0

// ==== rtl/register_file.sv ====
`timescale 1ns/1ns

module register_file (
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_pkg::reg_addr_t rs1,
    input  cpu_pkg::reg_addr_t rs2,
    input  cpu_pkg::reg_addr_t rd,
    input  logic               reg_write,
    input  cpu_pkg::word_t     wb_data,
    output cpu_pkg::word_t     rs1_data,
    output cpu_pkg::word_t     rs2_data
);
    import cpu_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write && rd != '0) begin
            regs[rd] <= wb_data;            // x0 is never written.
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    // No instruction stream may ever leave a value in x0.
    x0_reads_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        ((rs1 == '0) |-> (rs1_data == '0)) and ((rs2 == '0) |-> (rs2_data == '0))
    ) else $error("register_file: x0 read back nonzero");

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpu_tb -f list.f -o cpu_sim

# A failing run exits nonzero, so the log decides the result.
./obj_dir/cpu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "Simulation failed."
    exit 1
fi
echo "Simulation passed."
